// ==== build.f ====
design/fetch_pkg.sv
design/fetch_sub_if.sv
design/inst_buffer_if.sv
design/inst_scratch_mem.sv
design/early_decode.sv
design/inst_buffer.sv
design/fetch_unit.sv
design/fetch_top.sv
verif/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv -f build.f --top-module fetch_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vfetch_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1

// ==== verif/fetch_tb.sv ====
////////////////////////////////////////////////////////////
// Fetch stage testbench
// Loads a program into scratch memory, pops entries under
// a table of pop rates and redirects, and checks order,
// words and decode hints against a reference model
////////////////////////////////////////////////////////////
module fetch_tb;
    import fetch_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 10;
    localparam int PROG_BASE    = 32;
    localparam int PROG_WORDS   = 32;
    localparam int NUM_ROWS     = 7;
    // Pop-free cycles after which the buffer must hold an entry
    localparam int STALL_LIMIT  = 4;

    typedef struct packed {
        int          pop_count;
        int          pop_pct;
        logic        redir;
        logic [31:0] target;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        load_en;
    logic [7:0]  load_addr;
    logic [31:0] load_data;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        pop;
    logic        entry_valid;
    logic [31:0] entry_pc;
    logic [31:0] entry_instruction;
    logic        entry_uses_rs1;
    logic        entry_uses_rs2;
    logic        entry_uses_rd;
    logic        entry_rd_zero;
    logic        entry_is_call;
    logic        entry_is_return;
    logic [31:0] fetch_pc;

    // Words for PC 0x80 upward in rows of four
    logic [31:0] program_words [PROG_WORDS] = '{
        // lui x5 / auipc x0 / jal x1 / jal x0
        32'h000012b7, 32'h00000017, 32'h008000ef, 32'h0100006f,
        // jalr x1,x1 / ret / jalr x1,x5 / jalr x0,x5
        32'h000080e7, 32'h00008067, 32'h000280e7, 32'h00028067,
        // jalr x1,x10 / jalr x0,x10 / beq / sw
        32'h000500e7, 32'h00050067, 32'h00b50463, 32'h00c5a023,
        // lw / addi / add / fence
        32'h0005a503, 32'h00150513, 32'h00b50533, 32'h0ff0000f,
        // amoadd / ecall / csrrw x0 / csrrwi
        32'h00b5a52f, 32'h00000073, 32'h30529073, 32'h3002d573,
        // ebreak / csrrs / add x1 / nop
        32'h00100073, 32'h30002573, 32'h000000b3, 32'h00000013,
        // beq x0 / lw x1 / jalr x5,x5 / jalr x5,x1
        32'h00000063, 32'h0000a083, 32'h000282e7, 32'h000082e7,
        // jal x5 / lui x0 / amoswap / beq back
        32'h000002ef, 32'h00000037, 32'h08b5a52f, 32'hfe000ee3
    };

    // Pops, pop percentage, redirect flag, redirect target
    row_t rows [NUM_ROWS] = '{
        '{6, 100, 1'b0, 32'h0000_0000},
        '{5, 25, 1'b0, 32'h0000_0000},
        '{4, 10, 1'b0, 32'h0000_0000},
        '{6, 50, 1'b1, 32'h0000_00a2},
        // Far address that wraps onto word 56
        '{8, 60, 1'b1, 32'hffff_f0e3},
        '{10, 70, 1'b1, 32'h0000_0084},
        '{12, 40, 1'b0, 32'h0000_0000}
    };

    logic [31:0] model_mem [256];
    bit          loaded [256];
    logic [31:0] exp_pc;
    integer      seed;
    int          error_count = 0;
    int          cycle_count = 0;
    int          timeout_limit = 0;

    always #CLK_HALF clk = ~clk;

    fetch_top u_dut (
        .clk               (clk),
        .rst               (rst),
        .load_en           (load_en),
        .load_addr         (load_addr),
        .load_data         (load_data),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .pop               (pop),
        .entry_valid       (entry_valid),
        .entry_pc          (entry_pc),
        .entry_instruction (entry_instruction),
        .entry_uses_rs1    (entry_uses_rs1),
        .entry_uses_rs2    (entry_uses_rs2),
        .entry_uses_rd     (entry_uses_rd),
        .entry_rd_zero     (entry_rd_zero),
        .entry_is_call     (entry_is_call),
        .entry_is_return   (entry_is_return),
        .fetch_pc          (fetch_pc)
    );

    ////////////////////////////////////////////////////////////
    // Checking helpers

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("ERR %0t: %s got %h, expected %h", $time, what, actual, expected);
            stop_run();
        end
    endtask

    // Hints as {uses_rs1, uses_rs2, uses_rd, rd_zero, is_call, is_return}
    function automatic logic [5:0] expected_hints(input logic [31:0] instr);
        logic [4:0] op;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic       rd_lnk;
        logic       rs1_lnk;
        logic       u1;
        logic       u2;
        logic       ud;
        op = instr[6:2];
        rd = instr[11:7];
        rs1 = instr[19:15];
        rd_lnk = (rd == 5'd1) || (rd == 5'd5);
        rs1_lnk = (rs1 == 5'd1) || (rs1 == 5'd5);
        u1 = !(op == LUI_T || op == AUIPC_T || op == JAL_T || op == FENCE_T);
        u2 = (op == BRANCH_T || op == STORE_T || op == ARITH_T || op == AMO_T);
        ud = !(op == BRANCH_T || op == STORE_T || op == FENCE_T);
        if (op == SYSTEM_T && (instr[14] || instr[14:12] == 3'b000)) begin
            u1 = 1'b0;
        end
        if (op == SYSTEM_T && instr[14:12] == 3'b000) begin
            ud = 1'b0;
        end
        if ((op == JAL_T || op == JALR_T) && rd == 5'd0) begin
            ud = 1'b0;
        end
        return {u1, u2, ud, rd == 5'd0, (op == JAL_T || op == JALR_T) && rd_lnk,
                op == JALR_T && rs1_lnk && (!rd_lnk || rd != rs1)};
    endfunction

    function automatic bit pop_roll(input int pct);
        int unsigned roll;
        roll = $unsigned($random(seed)) % 100;
        return roll < pct;
    endfunction

    // Head entry against the model, then step the expected PC
    task automatic check_entry();
        logic [7:0] idx;
        logic [5:0] hints_got;
        idx = exp_pc[9:2];
        hints_got = {entry_uses_rs1, entry_uses_rs2, entry_uses_rd,
                     entry_rd_zero, entry_is_call, entry_is_return};
        if (!loaded[idx]) begin
            $display("Expected pc %h points at a word the program never loaded", exp_pc);
            stop_run();
        end
        check_value(entry_pc, exp_pc, "entry pc");
        check_value(entry_instruction, model_mem[idx], "entry instruction");
        check_value({26'd0, hints_got}, {26'd0, expected_hints(model_mem[idx])},
                    "entry hint flags");
        exp_pc = exp_pc + 32'd4;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            $display("Run hung: no completion within %0d cycles", timeout_limit);
            stop_run();
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        logic [7:0] widx;
        row_t       row;
        int         popped;
        int         no_pop_cycles;
        int         total_pops;
        rst = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        redirect = 1'b0;
        redirect_pc = '0;
        pop = 1'b0;
        seed = 32'h18bc;
        total_pops = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            total_pops += rows[r[2:0]].pop_count;
        end
        timeout_limit = 20 * total_pops + 200;

        // Reset covers the first words and redirect holds fetch at the vector for the rest
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(negedge clk);
            if (i == RESET_CYCLES) begin
                check_value({31'd0, entry_valid}, 32'd0, "entry_valid after reset");
                check_value(fetch_pc, RESET_VEC, "fetch_pc after reset");
                rst = 1'b0;
                redirect = 1'b1;
                redirect_pc = RESET_VEC;
            end
            widx = 8'(PROG_BASE + i);
            load_en = 1'b1;
            load_addr = widx;
            load_data = program_words[i[4:0]];
            model_mem[widx] = program_words[i[4:0]];
            loaded[widx] = 1'b1;
        end
        @(negedge clk);
        load_en = 1'b0;
        redirect = 1'b0;
        check_value(fetch_pc, RESET_VEC, "fetch_pc before first fetch");
        exp_pc = RESET_VEC;
        no_pop_cycles = 0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            row = rows[r[2:0]];
            if (row.redir) begin
                @(negedge clk);
                pop = 1'b0;
                redirect = 1'b1;
                redirect_pc = row.target;
                @(negedge clk);
                redirect = 1'b0;
                exp_pc = {row.target[31:2], 2'b00};
                no_pop_cycles = 0;
            end
            popped = 0;
            while (popped < row.pop_count) begin
                @(negedge clk);
                pop = 1'b0;
                if (entry_valid && pop_roll(row.pop_pct)) begin
                    check_entry();
                    pop = 1'b1;
                    popped++;
                    no_pop_cycles = 0;
                end else begin
                    if (!entry_valid && no_pop_cycles >= STALL_LIMIT) begin
                        $display("Buffer still empty %0d cycles after the last pop at %0t",
                                 no_pop_cycles, $time);
                        stop_run();
                    end
                    no_pop_cycles++;
                end
            end
        end
        @(negedge clk);
        pop = 1'b0;

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== design/fetch_top.sv ====
////////////////////////////////////////////////////////////
// Fetch stage top level
// Fetch unit, scratch memory and instruction buffer, with
// the buffer head split out onto plain ports
////////////////////////////////////////////////////////////
module fetch_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        load_en,
    input  logic [7:0]  load_addr,
    input  logic [31:0] load_data,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    input  logic        pop,
    output logic        entry_valid,
    output logic [31:0] entry_pc,
    output logic [31:0] entry_instruction,
    output logic        entry_uses_rs1,
    output logic        entry_uses_rs2,
    output logic        entry_uses_rd,
    output logic        entry_rd_zero,
    output logic        entry_is_call,
    output logic        entry_is_return,
    output logic [31:0] fetch_pc
);

    fetch_sub_if   sub_bus ();
    inst_buffer_if ib_bus ();

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .sub         (sub_bus.fetch),
        .ib          (ib_bus.fetch),
        .fetch_pc    (fetch_pc)
    );

    inst_scratch_mem u_scratch_mem (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .fetch_sub (sub_bus.unit)
    );

    inst_buffer u_inst_buffer (
        .clk (clk),
        .rst (rst),
        .ib  (ib_bus.buffer)
    );

    // Consumer side of the buffer
    assign ib_bus.pop = pop;

    assign entry_valid       = ib_bus.valid;
    assign entry_pc          = ib_bus.data_out.pc;
    assign entry_instruction = ib_bus.data_out.instruction;
    assign entry_uses_rs1    = ib_bus.data_out.uses_rs1;
    assign entry_uses_rs2    = ib_bus.data_out.uses_rs2;
    assign entry_uses_rd     = ib_bus.data_out.uses_rd;
    assign entry_rd_zero     = ib_bus.data_out.rd_zero;
    assign entry_is_call     = ib_bus.data_out.is_call;
    assign entry_is_return   = ib_bus.data_out.is_return;

endmodule

// ==== design/fetch_unit.sv ====
////////////////////////////////////////////////////////////
// Fetch unit
// Owns the PC, issues one word request per cycle while the
// buffer has room, pre-decodes returned words and pushes
// them into the instruction buffer. Redirect flushes the
// stage and restarts at the new PC
////////////////////////////////////////////////////////////
module fetch_unit (
    input  logic         clk,
    input  logic         rst,
    input  logic         redirect,
    input  logic [31:0]  redirect_pc,
    fetch_sub_if.fetch   sub,
    inst_buffer_if.fetch ib,
    output logic [31:0]  fetch_pc
);
    import fetch_pkg::*;

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        update_pc;

    logic        mem_ready;
    logic        space_in_buffer;
    logic [BUFFER_CNT_W-1:0] in_flight;

    logic [31:0]  stage2_pc;
    fetch_entry_t entry;

    logic uses_rs1;
    logic uses_rs2;
    logic uses_rd;
    logic rd_zero;
    logic is_call;
    logic is_return;

    ////////////////////////////////////////////////////////////
    // PC

    assign mem_ready = sub.ready && space_in_buffer && !redirect && !rst;
    assign update_pc = mem_ready || redirect;

    always_comb begin
        if (redirect) begin
            next_pc = {redirect_pc[31:2], 2'b00};
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_VEC;
        end else if (update_pc) begin
            pc <= next_pc;
        end
    end

    assign fetch_pc = pc;

    ////////////////////////////////////////////////////////////
    // Request issue

    assign sub.new_request = mem_ready;
    assign sub.stage1_addr = pc;

    // PC of the word coming back next cycle
    always_ff @(posedge clk) begin
        if (mem_ready) begin
            stage2_pc <= pc;
        end
    end

    // Issued requests plus buffered entries
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            in_flight       <= '0;
            space_in_buffer <= 1'b1;
        end else if (mem_ready && !ib.pop) begin
            in_flight       <= in_flight + 1'b1;
            space_in_buffer <= in_flight < BUFFER_CNT_W'(FETCH_BUFFER_DEPTH - 1);
        end else if (!mem_ready && ib.pop) begin
            in_flight       <= in_flight - 1'b1;
            space_in_buffer <= 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Entry assembly

    early_decode u_early_decode (
        .instruction (sub.data_out),
        .uses_rs1    (uses_rs1),
        .uses_rs2    (uses_rs2),
        .uses_rd     (uses_rd),
        .rd_zero     (rd_zero),
        .is_call     (is_call),
        .is_return   (is_return)
    );

    always_comb begin
        entry.pc          = stage2_pc;
        entry.instruction = sub.data_out;
        entry.uses_rs1    = uses_rs1;
        entry.uses_rs2    = uses_rs2;
        entry.uses_rd     = uses_rd;
        entry.rd_zero     = rd_zero;
        entry.is_call     = is_call;
        entry.is_return   = is_return;
    end

    // Word returning in a redirect cycle is dropped
    assign ib.push    = sub.data_valid && !redirect;
    assign ib.flush   = redirect;
    assign ib.data_in = entry;

    a_in_flight_bound : assert property (
        @(posedge clk) disable iff (rst)
        in_flight <= BUFFER_CNT_W'(FETCH_BUFFER_DEPTH)
    );

    // A push always answers a request accepted one cycle earlier
    a_push_after_accept : assert property (
        @(posedge clk) disable iff (rst)
        ib.push |-> $past(sub.new_request && sub.ready)
    );

endmodule

// ==== design/inst_buffer.sv ====
////////////////////////////////////////////////////////////
// Instruction buffer
// Circular FIFO of pre-decoded fetch entries. Head entry is
// shown on data_out; flush empties it in one cycle
////////////////////////////////////////////////////////////
module inst_buffer (
    input  logic          clk,
    input  logic          rst,
    inst_buffer_if.buffer ib
);
    import fetch_pkg::*;

    fetch_entry_t entries [FETCH_BUFFER_DEPTH];

    logic [BUFFER_PTR_W-1:0] wr_ptr;
    logic [BUFFER_PTR_W-1:0] rd_ptr;
    logic [BUFFER_CNT_W-1:0] count;

    logic do_push;
    logic do_pop;
    logic full;

    // Flush cycle drops any push
    assign do_push = ib.push && !ib.flush;
    assign do_pop  = ib.pop && !ib.flush;

    assign full     = (count == BUFFER_CNT_W'(FETCH_BUFFER_DEPTH));
    assign ib.valid = (count != '0);

    ////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= ib.data_in;
        end
    end

    assign ib.data_out = entries[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Pointers and count

    always_ff @(posedge clk) begin
        if (rst || ib.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == BUFFER_PTR_W'(FETCH_BUFFER_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == BUFFER_PTR_W'(FETCH_BUFFER_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (!do_push && do_pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // Fetch-side slot accounting must keep these from happening
    a_no_push_full : assert property (
        @(posedge clk) disable iff (rst)
        (ib.push && !ib.flush) |-> !full
    );

    a_no_pop_empty : assert property (
        @(posedge clk) disable iff (rst)
        ib.pop |-> ib.valid
    );

endmodule

// ==== design/early_decode.sv ====
////////////////////////////////////////////////////////////
// Early decode
// Register-use, rd-zero and call/return hints for one RV32
// instruction word, purely combinational
////////////////////////////////////////////////////////////
module early_decode (
    input  logic [31:0] instruction,
    output logic        uses_rs1,
    output logic        uses_rs2,
    output logic        uses_rd,
    output logic        rd_zero,
    output logic        is_call,
    output logic        is_return
);
    import fetch_pkg::*;

    logic [4:0] opcode_trimmed;
    logic [2:0] fn3;
    logic [4:0] rs1_addr;
    logic [4:0] rd_addr;

    logic csr_imm_op;
    logic sys_op;
    logic is_jump;
    logic jump_to_x0;
    logic rs1_link;
    logic rd_link;

    assign opcode_trimmed = instruction[6:2];
    assign fn3            = instruction[14:12];
    assign rs1_addr       = instruction[19:15];
    assign rd_addr        = instruction[11:7];

    // CSR immediate forms and ecall/ebreak/xret
    assign csr_imm_op = (opcode_trimmed == SYSTEM_T) && fn3[2];
    assign sys_op     = (opcode_trimmed == SYSTEM_T) && (fn3 == 3'b000);

    assign is_jump    = (opcode_trimmed == JAL_T) || (opcode_trimmed == JALR_T);
    assign jump_to_x0 = is_jump && (rd_addr == 5'd0);

    // Link registers x1 and x5
    assign rs1_link = (rs1_addr == 5'd1) || (rs1_addr == 5'd5);
    assign rd_link  = (rd_addr == 5'd1) || (rd_addr == 5'd5);

    ////////////////////////////////////////////////////////////
    // Hints

    assign uses_rs1 = !((opcode_trimmed inside {LUI_T, AUIPC_T, JAL_T, FENCE_T})
                        || csr_imm_op || sys_op);

    assign uses_rs2 = opcode_trimmed inside {BRANCH_T, STORE_T, ARITH_T, AMO_T};

    assign uses_rd = !((opcode_trimmed inside {BRANCH_T, STORE_T, FENCE_T})
                       || sys_op || jump_to_x0);

    assign rd_zero = (rd_addr == 5'd0);

    assign is_call = is_jump && rd_link;

    // Pop unless rd links back to the same register (coroutine swap)
    assign is_return = (opcode_trimmed == JALR_T) && rs1_link
                       && (!rd_link || (rd_addr != rs1_addr));

endmodule

// ==== design/inst_scratch_mem.sv ====
////////////////////////////////////////////////////////////
// Instruction scratch memory
// Synchronous single-read word RAM serving fetch requests,
// always ready, data one cycle after the request.
// Separate write port for program loading
////////////////////////////////////////////////////////////
module inst_scratch_mem (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              load_en,
    input  logic [fetch_pkg::SCRATCH_ADDR_W-1:0] load_addr,
    input  logic [31:0]                       load_data,
    fetch_sub_if.unit                         fetch_sub
);
    import fetch_pkg::*;

    logic [31:0] mem [SCRATCH_WORDS];
    logic [SCRATCH_ADDR_W-1:0] read_addr;
    logic [31:0] read_word;
    logic read_pending;

    // Addresses wrap inside the scratch range
    assign read_addr = fetch_sub.stage1_addr[SCRATCH_ADDR_W+1:2];

    assign fetch_sub.ready = 1'b1;

    ////////////////////////////////////////////////////////////
    // Load port

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port
    // Same-cycle write to the read word gives the old value

    always_ff @(posedge clk) begin
        if (fetch_sub.new_request) begin
            read_word <= mem[read_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            read_pending <= 1'b0;
        end else begin
            read_pending <= fetch_sub.new_request;
        end
    end

    assign fetch_sub.data_valid = read_pending;
    assign fetch_sub.data_out   = read_word;

endmodule

// ==== design/inst_buffer_if.sv ====
////////////////////////////////////////////////////////////
// Instruction buffer interface
// Push and flush from fetch, head entry and pop to consumer
////////////////////////////////////////////////////////////
interface inst_buffer_if;
    import fetch_pkg::*;

    logic         push;
    logic         flush;
    fetch_entry_t data_in;

    logic         valid;
    fetch_entry_t data_out;
    logic         pop;

    // Fetch watches pop to release in-flight slots
    modport fetch (output push, flush, data_in, input pop);

    modport buffer (
        input  push, flush, data_in, pop,
        output valid, data_out
    );

    modport consumer (input valid, data_out, output pop);

endinterface

// ==== design/fetch_sub_if.sv ====
////////////////////////////////////////////////////////////
// Fetch sub-unit interface
// Word request from the fetch unit, one-cycle data return
////////////////////////////////////////////////////////////
interface fetch_sub_if;

    // Request side
    logic        new_request;
    logic [31:0] stage1_addr;

    // Return side
    logic        ready;
    logic        data_valid;
    logic [31:0] data_out;

    modport fetch (
        output new_request, stage1_addr,
        input  ready, data_valid, data_out
    );

    modport unit (
        input  new_request, stage1_addr,
        output ready, data_valid, data_out
    );

endinterface

// ==== design/fetch_pkg.sv ====
////////////////////////////////////////////////////////////
// Fetch package
// Shared sizes, reset vector, trimmed RV32 opcodes and the
// pre-decoded instruction buffer entry
////////////////////////////////////////////////////////////
package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes

    localparam logic [31:0] RESET_VEC = 32'h0000_0080;

    // Also bounds requests in flight plus buffered entries
    localparam int FETCH_BUFFER_DEPTH = 4;
    localparam int BUFFER_PTR_W = $clog2(FETCH_BUFFER_DEPTH);
    localparam int BUFFER_CNT_W = $clog2(FETCH_BUFFER_DEPTH + 1);

    // Word index is pc[9:2]
    localparam int SCRATCH_WORDS = 256;
    localparam int SCRATCH_ADDR_W = 8;

    ////////////////////////////////////////////////////////////
    // Opcodes from instruction bits 6:2

    localparam logic [4:0] LUI_T       = 5'b01101;
    localparam logic [4:0] AUIPC_T     = 5'b00101;
    localparam logic [4:0] JAL_T       = 5'b11011;
    localparam logic [4:0] JALR_T      = 5'b11001;
    localparam logic [4:0] BRANCH_T    = 5'b11000;
    localparam logic [4:0] LOAD_T      = 5'b00000;
    localparam logic [4:0] STORE_T     = 5'b01000;
    localparam logic [4:0] ARITH_IMM_T = 5'b00100;
    localparam logic [4:0] ARITH_T     = 5'b01100;
    localparam logic [4:0] FENCE_T     = 5'b00011;
    localparam logic [4:0] AMO_T       = 5'b01011;
    localparam logic [4:0] SYSTEM_T    = 5'b11100;

    ////////////////////////////////////////////////////////////
    // Buffer entry of 70 bits

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instruction;
        logic        uses_rs1;
        logic        uses_rs2;
        logic        uses_rd;
        logic        rd_zero;
        logic        is_call;
        logic        is_return;
    } fetch_entry_t;

endpackage
